// ==== design/dma_noc_params.svh ====
//////////////////////////////
// Widths, table depth and header field positions for the DMA request path
// Include in every file that sizes a port or picks a flit field
//////////////////////////////
`ifndef DMA_NOC_PARAMS_SVH
`define DMA_NOC_PARAMS_SVH

`define DMA_ADDR_WIDTH      32
`define DMA_DATA_WIDTH      32
`define DMA_FLIT_WIDTH      34
`define DMA_TABLE_ENTRIES   4
`define DMA_TABLE_PTR_WIDTH 2
`define DMA_SIZE_WIDTH      12
`define DMA_TILE_WIDTH      5
// Max flits per L2R packet, header and address included
`define DMA_NOC_PACKET_SIZE 8

// Flit type sits above the 32 content bits
`define DMA_FLIT_TYPE_MSB   33
`define DMA_FLIT_TYPE_LSB   32

// Header flit content layout
`define DMA_HDR_DEST_MSB    31
`define DMA_HDR_DEST_LSB    27
`define DMA_HDR_CLASS_MSB   26
`define DMA_HDR_CLASS_LSB   24
`define DMA_HDR_ID_MSB      23
`define DMA_HDR_ID_LSB      22
`define DMA_HDR_SRC_MSB     21
`define DMA_HDR_SRC_LSB     17
`define DMA_HDR_PTYPE_MSB   16
`define DMA_HDR_PTYPE_LSB   15
// Set on the final packet of a request
`define DMA_HDR_LAST        14
`define DMA_HDR_SIZE_MSB    11
`define DMA_HDR_SIZE_LSB    0

`endif

// ==== design/dma_noc_pkg.sv ====
//////////////////////////////
// Flit, packet and direction encodings shared by the DMA request path
//////////////////////////////
package dma_noc_pkg;

  // Two type bits on top of every flit
  typedef enum logic [1:0] {
    FLIT_PAYLOAD = 2'b00,
    FLIT_HEADER  = 2'b01,
    FLIT_LAST    = 2'b10
  } flit_type_e;

  // Packet type field of the header
  typedef enum logic [1:0] {
    PKT_L2R_REQ = 2'b00,
    PKT_R2L_REQ = 2'b01
  } packet_type_e;

  // Transfer direction of a descriptor
  // L2R pushes local words out, R2L asks the remote tile for words
  typedef enum logic {
    DMA_L2R = 1'b0,
    DMA_R2L = 1'b1
  } dma_dir_e;

  // Class written into every DMA header
  localparam logic [2:0] PACKET_CLASS_DMA = 3'b010;

endpackage

// ==== design/dma_rr_arbiter.sv ====
//////////////////////////////
// Round-robin next-grant logic, one-hot in and out
//////////////////////////////
`timescale 1ns/100ps

module dma_rr_arbiter #(
  parameter int N = 4
) (
  input  logic [N-1:0] req,
  input  logic [N-1:0] gnt,
  output logic [N-1:0] nxt_gnt
);

  logic [N-1:0] above;
  logic [N-1:0] masked;

  // Positions strictly after the current grant
  // An empty grant masks everything, so the plain requests decide
  assign above  = ~(gnt | (gnt - 1'b1));
  assign masked = req & above;

  always_comb begin
    if (|masked)
      // Lowest requester after the grant
      nxt_gnt = masked & (~masked + 1'b1);
    else if (|req)
      // Wrap around to the lowest requester
      nxt_gnt = req & (~req + 1'b1);
    else
      nxt_gnt = gnt;
  end

endmodule

// ==== design/dma_request_table.sv ====
//////////////////////////////
// Descriptor table of the DMA initiator
// Host loads entries by four-phase req/ack, the request generator reads them
//////////////////////////////
`timescale 1ns/100ps
`include "dma_noc_params.svh"

module dma_request_table import dma_noc_pkg::*; (
  input  logic                            clk,
  input  logic                            rst,
  // Host load port
  input  logic                            cfg_req,
  output logic                            cfg_ack,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0] cfg_pos,
  input  dma_dir_e                        cfg_dir,
  input  logic [`DMA_TILE_WIDTH-1:0]      cfg_rtile,
  input  logic [`DMA_ADDR_WIDTH-1:0]      cfg_raddr,
  input  logic [`DMA_ADDR_WIDTH-1:0]      cfg_laddr,
  input  logic [`DMA_SIZE_WIDTH-1:0]      cfg_size,
  // Read port
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0] read_pos,
  output logic [`DMA_TABLE_ENTRIES-1:0]   valid,
  output dma_dir_e                        rd_dir,
  output logic [`DMA_TILE_WIDTH-1:0]      rd_rtile,
  output logic [`DMA_ADDR_WIDTH-1:0]      rd_raddr,
  output logic [`DMA_ADDR_WIDTH-1:0]      rd_laddr,
  output logic [`DMA_SIZE_WIDTH-1:0]      rd_size,
  // Completion from the response side
  input  logic                            done_en,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0] done_pos
);

  dma_dir_e                   dir_q   [`DMA_TABLE_ENTRIES];
  logic [`DMA_TILE_WIDTH-1:0] rtile_q [`DMA_TABLE_ENTRIES];
  logic [`DMA_ADDR_WIDTH-1:0] raddr_q [`DMA_TABLE_ENTRIES];
  logic [`DMA_ADDR_WIDTH-1:0] laddr_q [`DMA_TABLE_ENTRIES];
  logic [`DMA_SIZE_WIDTH-1:0] size_q  [`DMA_TABLE_ENTRIES];
  logic                       load;

  // Write on the first req cycle and ack one cycle later
  assign load = cfg_req && !cfg_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_ack <= 1'b0;
      valid   <= '0;
    end else begin
      cfg_ack <= cfg_req;
      // Done clears first so a same-cycle load still lands
      if (done_en)
        valid[done_pos] <= 1'b0;
      if (load)
        valid[cfg_pos] <= 1'b1;
    end
  end

  // Descriptor payload
  always_ff @(posedge clk) begin
    if (load) begin
      dir_q[cfg_pos]   <= cfg_dir;
      rtile_q[cfg_pos] <= cfg_rtile;
      raddr_q[cfg_pos] <= cfg_raddr;
      laddr_q[cfg_pos] <= cfg_laddr;
      size_q[cfg_pos]  <= cfg_size;
    end
  end

  assign rd_dir   = dir_q[read_pos];
  assign rd_rtile = rtile_q[read_pos];
  assign rd_raddr = raddr_q[read_pos];
  assign rd_laddr = laddr_q[read_pos];
  assign rd_size  = size_q[read_pos];

  //////////////////////////////
  // Handshake checks
  // A new request waits until the previous ack has dropped
  a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(cfg_req) |-> !cfg_ack);
  a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    load |-> !valid[cfg_pos]);

endmodule

// ==== design/dma_local_reader.sv ====
//////////////////////////////
// Fetches L2R payload words from local memory
// Started by the request generator, hands words over through a two-entry buffer
//////////////////////////////
`timescale 1ns/100ps
`include "dma_noc_params.svh"

module dma_local_reader (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic                       is_l2r,
  input  logic [`DMA_ADDR_WIDTH-1:0] laddr,
  input  logic [`DMA_SIZE_WIDTH-1:0] size,
  output logic [`DMA_DATA_WIDTH-1:0] data,
  output logic                       data_valid,
  input  logic                       data_ready,
  output logic                       mem_en,
  output logic [`DMA_ADDR_WIDTH-1:0] mem_addr,
  input  logic [`DMA_DATA_WIDTH-1:0] mem_rdata
);

  logic [`DMA_SIZE_WIDTH-1:0] remaining;
  logic [`DMA_ADDR_WIDTH-1:0] rd_addr;
  logic                       rd_pending;
  logic [`DMA_DATA_WIDTH-1:0] buf_q [2];
  logic [1:0]                 buf_cnt;
  logic                       wr_ptr;
  logic                       rd_ptr;
  logic [1:0]                 inflight;
  logic                       pop;

  // Reads in flight plus words held, never more than two
  assign inflight   = buf_cnt + 2'(rd_pending);
  assign mem_en     = (remaining != '0) && (inflight < 2'd2);
  assign mem_addr   = rd_addr;
  assign data       = buf_q[rd_ptr];
  assign data_valid = (buf_cnt != 2'd0);
  assign pop        = data_ready && data_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining  <= '0;
      rd_pending <= 1'b0;
      buf_cnt    <= 2'd0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
    end else begin
      // Memory answers one cycle after mem_en
      rd_pending <= mem_en;
      if (start && is_l2r)
        remaining <= size;
      else if (mem_en)
        remaining <= remaining - 1'b1;
      buf_cnt <= buf_cnt + 2'(rd_pending) - 2'(pop);
      if (rd_pending)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
    end
  end

  // Word address and captured data
  always_ff @(posedge clk) begin
    if (start)
      rd_addr <= laddr;
    else if (mem_en)
      rd_addr <= rd_addr + 3'd4;
    if (rd_pending)
      buf_q[wr_ptr] <= mem_rdata;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    (rd_pending && !pop) |-> (buf_cnt != 2'd2));

endmodule

// ==== design/dma_noc_req_gen.sv ====
//////////////////////////////
// Picks open table entries and turns them into NoC request flits
// One request is on the NoC at a time, finished ones wait for done
//////////////////////////////
`timescale 1ns/100ps
`include "dma_noc_params.svh"

module dma_noc_req_gen import dma_noc_pkg::*; #(
  parameter logic [`DMA_TILE_WIDTH-1:0] TILE_ID = '0
) (
  input  logic                            clk,
  input  logic                            rst,
  // Table read port
  input  logic [`DMA_TABLE_ENTRIES-1:0]   valid,
  output logic [`DMA_TABLE_PTR_WIDTH-1:0] read_pos,
  input  dma_dir_e                        rd_dir,
  input  logic [`DMA_TILE_WIDTH-1:0]      rd_rtile,
  input  logic [`DMA_ADDR_WIDTH-1:0]      rd_raddr,
  input  logic [`DMA_ADDR_WIDTH-1:0]      rd_laddr,
  input  logic [`DMA_SIZE_WIDTH-1:0]      rd_size,
  input  logic                            done_en,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0] done_pos,
  // Local reader
  output logic                            start,
  output logic [`DMA_ADDR_WIDTH-1:0]      laddr,
  output logic [`DMA_SIZE_WIDTH-1:0]      size,
  output logic                            is_l2r,
  input  logic [`DMA_DATA_WIDTH-1:0]      data,
  input  logic                            data_valid,
  output logic                            data_ready,
  // NoC output
  output logic [`DMA_FLIT_WIDTH-1:0]      noc_out_flit,
  output logic                            noc_out_valid,
  input  logic                            noc_out_ready
);

  localparam logic [`DMA_SIZE_WIDTH-1:0] PKT_WORDS = `DMA_SIZE_WIDTH'(`DMA_NOC_PACKET_SIZE - 2);

  typedef enum logic [2:0] {
    ST_IDLE, ST_L2R_HDR, ST_L2R_ADDR, ST_L2R_DATA,
    ST_R2L_HDR, ST_R2L_SIZE, ST_R2L_RADDR, ST_R2L_LADDR
  } state_e;

  state_e                          state, state_nxt;
  logic [`DMA_TABLE_ENTRIES-1:0]   select, select_nxt;
  logic [`DMA_TABLE_ENTRIES-1:0]   open_resp, open_nxt;
  logic [`DMA_TABLE_ENTRIES-1:0]   selectable;
  logic [`DMA_TABLE_ENTRIES-1:0]   requests;
  logic                            idle;
  // Words already sent, and the position inside the current packet
  logic [`DMA_SIZE_WIDTH-1:0]      sent, sent_nxt;
  logic [`DMA_SIZE_WIDTH-1:0]      pkt_cnt, pkt_cnt_nxt;
  logic [`DMA_SIZE_WIDTH-1:0]      pkt_size, pkt_size_nxt;
  logic [`DMA_SIZE_WIDTH-1:0]      remaining;
  logic                            l2r_last;
  logic [`DMA_SIZE_WIDTH-1:0]      l2r_words;

  // Header content from type, size and last bit
  function automatic logic [`DMA_DATA_WIDTH-1:0] hdr_flit(
    input logic [`DMA_TILE_WIDTH-1:0]      dest,
    input logic [`DMA_TABLE_PTR_WIDTH-1:0] id,
    input packet_type_e                    ptype,
    input logic [`DMA_SIZE_WIDTH-1:0]      sz,
    input logic                            last
  );
    logic [`DMA_DATA_WIDTH-1:0] h;
    h = '0;
    h[`DMA_HDR_DEST_MSB:`DMA_HDR_DEST_LSB]   = dest;
    h[`DMA_HDR_CLASS_MSB:`DMA_HDR_CLASS_LSB] = PACKET_CLASS_DMA;
    h[`DMA_HDR_ID_MSB:`DMA_HDR_ID_LSB]       = id;
    h[`DMA_HDR_SRC_MSB:`DMA_HDR_SRC_LSB]     = TILE_ID;
    h[`DMA_HDR_PTYPE_MSB:`DMA_HDR_PTYPE_LSB] = ptype;
    h[`DMA_HDR_LAST]                         = last;
    h[`DMA_HDR_SIZE_MSB:`DMA_HDR_SIZE_LSB]   = sz;
    return h;
  endfunction

  //////////////////////////////
  // Entry selection
  assign idle       = (state == ST_IDLE);
  assign selectable = valid & ~open_resp;
  // Grant only moves while idle and before the start pulse
  assign requests   = selectable & {`DMA_TABLE_ENTRIES{idle && !start}};

  dma_rr_arbiter #(.N(`DMA_TABLE_ENTRIES)) i_arbiter (
    .req     (requests),
    .gnt     (select),
    .nxt_gnt (select_nxt)
  );

  // One-hot grant to table position
  always_comb begin
    read_pos = '0;
    for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) begin
      if (select[i])
        read_pos = read_pos | `DMA_TABLE_PTR_WIDTH'(i);
    end
  end

  assign laddr  = rd_laddr;
  assign size   = rd_size;
  assign is_l2r = (rd_dir == DMA_L2R);

  // Split of the L2R transfer into packets
  assign remaining = rd_size - sent;
  assign l2r_last  = (remaining <= PKT_WORDS);
  assign l2r_words = l2r_last ? remaining : PKT_WORDS;

  //////////////////////////////
  // Flit FSM
  always_comb begin
    state_nxt     = state;
    sent_nxt      = sent;
    pkt_cnt_nxt   = pkt_cnt;
    pkt_size_nxt  = pkt_size;
    open_nxt      = open_resp;
    noc_out_valid = 1'b0;
    noc_out_flit  = '0;
    data_ready    = 1'b0;
    case (state)
      ST_IDLE: begin
        sent_nxt = '0;
        if (start)
          state_nxt = is_l2r ? ST_L2R_HDR : ST_R2L_HDR;
      end
      ST_L2R_HDR: begin
        noc_out_valid = 1'b1;
        noc_out_flit  = {FLIT_HEADER, hdr_flit(rd_rtile, read_pos, PKT_L2R_REQ,
                                               l2r_words, l2r_last)};
        if (noc_out_ready) begin
          pkt_size_nxt = l2r_words;
          pkt_cnt_nxt  = `DMA_SIZE_WIDTH'(1);
          state_nxt    = ST_L2R_ADDR;
        end
      end
      ST_L2R_ADDR: begin
        // Remote address advances by the words already sent
        noc_out_valid = 1'b1;
        noc_out_flit  = {FLIT_PAYLOAD, rd_raddr + (`DMA_ADDR_WIDTH'(sent) << 2)};
        if (noc_out_ready)
          state_nxt = ST_L2R_DATA;
      end
      ST_L2R_DATA: begin
        noc_out_valid = data_valid;
        noc_out_flit  = {(pkt_cnt == pkt_size) ? FLIT_LAST : FLIT_PAYLOAD, data};
        if (noc_out_ready && data_valid) begin
          data_ready  = 1'b1;
          pkt_cnt_nxt = pkt_cnt + 1'b1;
          if (pkt_cnt == pkt_size) begin
            if (sent + pkt_cnt == rd_size) begin
              // Whole request out, wait for its response
              open_nxt  = open_resp | select;
              state_nxt = ST_IDLE;
            end else begin
              sent_nxt  = sent + pkt_cnt;
              state_nxt = ST_L2R_HDR;
            end
          end
        end
      end
      ST_R2L_HDR: begin
        // Single packet, size travels in its own flit
        noc_out_valid = 1'b1;
        noc_out_flit  = {FLIT_HEADER, hdr_flit(rd_rtile, read_pos, PKT_R2L_REQ,
                                               '0, 1'b1)};
        if (noc_out_ready)
          state_nxt = ST_R2L_SIZE;
      end
      ST_R2L_SIZE: begin
        noc_out_valid = 1'b1;
        noc_out_flit[`DMA_HDR_SIZE_MSB:`DMA_HDR_SIZE_LSB] = rd_size;
        if (noc_out_ready)
          state_nxt = ST_R2L_RADDR;
      end
      ST_R2L_RADDR: begin
        noc_out_valid = 1'b1;
        noc_out_flit  = {FLIT_PAYLOAD, rd_raddr};
        if (noc_out_ready)
          state_nxt = ST_R2L_LADDR;
      end
      ST_R2L_LADDR: begin
        noc_out_valid = 1'b1;
        noc_out_flit  = {FLIT_LAST, rd_laddr};
        if (noc_out_ready) begin
          open_nxt  = open_resp | select;
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
    // Response side closes the entry
    if (done_en)
      open_nxt[done_pos] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      select    <= '0;
      open_resp <= '0;
      start     <= 1'b0;
      sent      <= '0;
      pkt_cnt   <= '0;
      pkt_size  <= '0;
    end else begin
      state     <= state_nxt;
      select    <= select_nxt;
      open_resp <= open_nxt;
      // Single-cycle pulse once a selectable entry is seen while idle
      start     <= idle && !start && (|selectable);
      sent      <= sent_nxt;
      pkt_cnt   <= pkt_cnt_nxt;
      pkt_size  <= pkt_size_nxt;
    end
  end

  // Flit holds under back-pressure, data flits included
  a_flit_stable: assert property (@(posedge clk) disable iff (rst)
    (noc_out_valid && !noc_out_ready) |=> (noc_out_valid && $stable(noc_out_flit)));

endmodule

// ==== design/dma_initiator.sv ====
//////////////////////////////
// Request side of the tile DMA engine
// Host loads descriptors, requests leave on the NoC port
//////////////////////////////
`timescale 1ns/100ps
`include "dma_noc_params.svh"

module dma_initiator import dma_noc_pkg::*; #(
  parameter logic [`DMA_TILE_WIDTH-1:0] TILE_ID = '0
) (
  input  logic                            clk,
  input  logic                            rst,
  // Host load
  input  logic                            cfg_req,
  output logic                            cfg_ack,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0] cfg_pos,
  input  dma_dir_e                        cfg_dir,
  input  logic [`DMA_TILE_WIDTH-1:0]      cfg_rtile,
  input  logic [`DMA_ADDR_WIDTH-1:0]      cfg_raddr,
  input  logic [`DMA_ADDR_WIDTH-1:0]      cfg_laddr,
  input  logic [`DMA_SIZE_WIDTH-1:0]      cfg_size,
  // Completion report
  input  logic                            done_en,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0] done_pos,
  // NoC
  output logic [`DMA_FLIT_WIDTH-1:0]      noc_out_flit,
  output logic                            noc_out_valid,
  input  logic                            noc_out_ready,
  // Local memory
  output logic                            mem_en,
  output logic [`DMA_ADDR_WIDTH-1:0]      mem_addr,
  input  logic [`DMA_DATA_WIDTH-1:0]      mem_rdata
);

  logic [`DMA_TABLE_PTR_WIDTH-1:0] read_pos;
  logic [`DMA_TABLE_ENTRIES-1:0]   valid;
  dma_dir_e                        rd_dir;
  logic [`DMA_TILE_WIDTH-1:0]      rd_rtile;
  logic [`DMA_ADDR_WIDTH-1:0]      rd_raddr;
  logic [`DMA_ADDR_WIDTH-1:0]      rd_laddr;
  logic [`DMA_SIZE_WIDTH-1:0]      rd_size;
  // Generator to reader
  logic                            start;
  logic [`DMA_ADDR_WIDTH-1:0]      laddr;
  logic [`DMA_SIZE_WIDTH-1:0]      size;
  logic                            is_l2r;
  logic [`DMA_DATA_WIDTH-1:0]      data;
  logic                            data_valid;
  logic                            data_ready;

  dma_request_table i_table (
    .clk, .rst,
    .cfg_req, .cfg_ack, .cfg_pos, .cfg_dir,
    .cfg_rtile, .cfg_raddr, .cfg_laddr, .cfg_size,
    .read_pos, .valid,
    .rd_dir, .rd_rtile, .rd_raddr, .rd_laddr, .rd_size,
    .done_en, .done_pos
  );

  dma_noc_req_gen #(.TILE_ID(TILE_ID)) i_req_gen (
    .clk, .rst,
    .valid, .read_pos,
    .rd_dir, .rd_rtile, .rd_raddr, .rd_laddr, .rd_size,
    .done_en, .done_pos,
    .start, .laddr, .size, .is_l2r,
    .data, .data_valid, .data_ready,
    .noc_out_flit, .noc_out_valid, .noc_out_ready
  );

  dma_local_reader i_reader (
    .clk, .rst,
    .start, .is_l2r, .laddr, .size,
    .data, .data_valid, .data_ready,
    .mem_en, .mem_addr, .mem_rdata
  );

endmodule

// ==== verif/tb_dma_initiator.sv ====
//////////////////////////////
// Testbench for the DMA initiator with host, local memory and NoC sink models
// Runs R2L, L2R and round-robin scenarios checked by assertions
//////////////////////////////
`timescale 1ns/100ps
`include "dma_noc_params.svh"

module tb_dma_initiator import dma_noc_pkg::*; ();

  localparam logic [`DMA_TILE_WIDTH-1:0] TILE      = 5'd3;
  localparam logic [`DMA_DATA_WIDTH-1:0] MEM_PAT   = 32'h5AC3_96E1;
  localparam int                         TIMEOUT   = 2000;
  localparam int                         PKT_WORDS = `DMA_NOC_PACKET_SIZE - 2;

  logic                            clk;
  logic                            rst;
  logic                            cfg_req;
  logic                            cfg_ack;
  logic [`DMA_TABLE_PTR_WIDTH-1:0] cfg_pos;
  dma_dir_e                        cfg_dir;
  logic [`DMA_TILE_WIDTH-1:0]      cfg_rtile;
  logic [`DMA_ADDR_WIDTH-1:0]      cfg_raddr;
  logic [`DMA_ADDR_WIDTH-1:0]      cfg_laddr;
  logic [`DMA_SIZE_WIDTH-1:0]      cfg_size;
  logic                            done_en;
  logic [`DMA_TABLE_PTR_WIDTH-1:0] done_pos;
  logic [`DMA_FLIT_WIDTH-1:0]      noc_out_flit;
  logic                            noc_out_valid;
  logic                            noc_out_ready;
  logic                            mem_en;
  logic [`DMA_ADDR_WIDTH-1:0]      mem_addr;
  logic [`DMA_DATA_WIDTH-1:0]      mem_rdata;
  // Address of the read issued on the coming rising edge
  logic [`DMA_ADDR_WIDTH-1:0]      pend_addr;
  // Offer on the NoC port as seen half a cycle before the edge
  logic                            offer_valid;
  logic [`DMA_FLIT_WIDTH-1:0]      offer_flit;
  // Transferred flits, oldest first
  logic [`DMA_FLIT_WIDTH-1:0]      flits [$];
  // Entries whose request went out and that still wait for done
  logic [`DMA_TABLE_ENTRIES-1:0]   sent_mask;
  integer                          seed;
  integer                          rnd;

  dma_initiator #(.TILE_ID(TILE)) i_dut (
    .clk, .rst,
    .cfg_req, .cfg_ack, .cfg_pos, .cfg_dir,
    .cfg_rtile, .cfg_raddr, .cfg_laddr, .cfg_size,
    .done_en, .done_pos,
    .noc_out_flit, .noc_out_valid, .noc_out_ready,
    .mem_en, .mem_addr, .mem_rdata
  );

  always #50 clk = ~clk;

  //////////////////////////////
  // Failure reporting
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic report_error(input string msg);
    stop_with_failure($sformatf("error at time %0t: %s", $time, msg));
  endtask

  //////////////////////////////
  // Memory and NoC sink models
  // Read data shows up one cycle after mem_en as the address XOR a pattern
  always @(negedge clk) begin
    mem_rdata = pend_addr ^ MEM_PAT;
    pend_addr = mem_addr;
  end

  // Roughly 11 of 16 cycles ready
  always @(negedge clk) begin
    rnd           = $random(seed);
    noc_out_ready = (rnd[3:0] < 4'd11);
    offer_valid   = noc_out_valid;
    offer_flit    = noc_out_flit;
  end

  // Records transfers and catches a request sent twice without done
  always @(posedge clk) begin
    if (rst) begin
      sent_mask <= '0;
    end else begin
      if (done_en)
        sent_mask[done_pos] <= 1'b0;
      if (offer_valid && noc_out_ready) begin
        flits.push_back(offer_flit);
        if (offer_flit[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] == FLIT_HEADER) begin
          assert (!sent_mask[offer_flit[`DMA_HDR_ID_MSB:`DMA_HDR_ID_LSB]])
            else report_error($sformatf("entry %0d sent again before done",
                                        offer_flit[`DMA_HDR_ID_MSB:`DMA_HDR_ID_LSB]));
          if (offer_flit[`DMA_HDR_LAST])
            sent_mask[offer_flit[`DMA_HDR_ID_MSB:`DMA_HDR_ID_LSB]] <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Protocol checks
  a_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(cfg_ack) |-> $past(cfg_req))
    else report_error("cfg_ack rose while cfg_req was low");
  a_ack_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(cfg_ack) |-> !$past(cfg_req))
    else report_error("cfg_ack fell while cfg_req was high");
  // Back-pressure must not change the offered flit
  a_flit_hold: assert property (@(posedge clk) disable iff (rst)
    (noc_out_valid && !noc_out_ready) |=> (noc_out_valid && $stable(noc_out_flit)))
    else report_error("flit changed or dropped under back-pressure");

  //////////////////////////////
  // Host and flit helpers
  task automatic load_entry(
    input int                         pos,
    input dma_dir_e                   dir,
    input logic [`DMA_TILE_WIDTH-1:0] rtile,
    input logic [`DMA_ADDR_WIDTH-1:0] raddr,
    input logic [`DMA_ADDR_WIDTH-1:0] laddr,
    input int                         words
  );
    int cycles;
    @(negedge clk);
    cfg_pos   = pos;
    cfg_dir   = dir;
    cfg_rtile = rtile;
    cfg_raddr = raddr;
    cfg_laddr = laddr;
    cfg_size  = words;
    cfg_req   = 1'b1;
    cycles    = 0;
    while (!cfg_ack) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        stop_with_failure("timeout: cfg_ack never rose during a descriptor load");
    end
    cfg_req = 1'b0;
    cycles  = 0;
    while (cfg_ack) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        stop_with_failure("timeout: cfg_ack never fell after cfg_req dropped");
    end
  endtask

  task automatic signal_done(input int pos);
    @(negedge clk);
    done_en  = 1'b1;
    done_pos = pos;
    @(negedge clk);
    done_en  = 1'b0;
  endtask

  task automatic wait_flits(input int n);
    int cycles;
    cycles = 0;
    while (flits.size() < n) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        stop_with_failure($sformatf("timeout: waited for %0d flits, only %0d arrived",
                                    n, flits.size()));
    end
  endtask

  // Nothing else may leave while every entry waits for done
  task automatic expect_quiet();
    repeat (20) @(negedge clk);
    assert (flits.size() == 0)
      else report_error($sformatf("%0d unexpected flits", flits.size()));
  endtask

  task automatic check_header(
    input logic [`DMA_FLIT_WIDTH-1:0] f,
    input int                         pos,
    input logic [`DMA_TILE_WIDTH-1:0] rtile,
    input packet_type_e               ptype,
    input int                         words,
    input logic                       last
  );
    assert (f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] == FLIT_HEADER)
      else report_error($sformatf("flit %h is not a header", f));
    assert (f[`DMA_HDR_DEST_MSB:`DMA_HDR_DEST_LSB] == rtile)
      else report_error($sformatf("header dest %0d, expected %0d",
                                  f[`DMA_HDR_DEST_MSB:`DMA_HDR_DEST_LSB], rtile));
    assert (f[`DMA_HDR_CLASS_MSB:`DMA_HDR_CLASS_LSB] == PACKET_CLASS_DMA)
      else report_error("header class is not the DMA class");
    assert (f[`DMA_HDR_ID_MSB:`DMA_HDR_ID_LSB] == pos)
      else report_error($sformatf("header id %0d, expected %0d",
                                  f[`DMA_HDR_ID_MSB:`DMA_HDR_ID_LSB], pos));
    assert (f[`DMA_HDR_SRC_MSB:`DMA_HDR_SRC_LSB] == TILE)
      else report_error("header source is not tile 3");
    assert (f[`DMA_HDR_PTYPE_MSB:`DMA_HDR_PTYPE_LSB] == ptype)
      else report_error("header packet type mismatch");
    assert (f[`DMA_HDR_LAST] == last)
      else report_error($sformatf("header last bit %0b, expected %0b",
                                  f[`DMA_HDR_LAST], last));
    // R2L carries its size in the next flit
    if (ptype == PKT_L2R_REQ)
      assert (f[`DMA_HDR_SIZE_MSB:`DMA_HDR_SIZE_LSB] == words)
        else report_error($sformatf("header size %0d, expected %0d",
                                    f[`DMA_HDR_SIZE_MSB:`DMA_HDR_SIZE_LSB], words));
  endtask

  // Header, size, remote address, local address
  task automatic check_r2l(
    input int                         pos,
    input logic [`DMA_TILE_WIDTH-1:0] rtile,
    input logic [`DMA_ADDR_WIDTH-1:0] raddr,
    input logic [`DMA_ADDR_WIDTH-1:0] laddr,
    input int                         words
  );
    logic [`DMA_FLIT_WIDTH-1:0] f;
    wait_flits(4);
    f = flits.pop_front();
    check_header(f, pos, rtile, PKT_R2L_REQ, words, 1'b1);
    f = flits.pop_front();
    assert (f[`DMA_HDR_SIZE_MSB:`DMA_HDR_SIZE_LSB] == words)
      else report_error($sformatf("R2L size flit %h, expected size %0d", f, words));
    f = flits.pop_front();
    assert (f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] == FLIT_PAYLOAD && f[31:0] == raddr)
      else report_error($sformatf("R2L raddr flit %h, expected %h", f, raddr));
    f = flits.pop_front();
    assert (f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] == FLIT_LAST && f[31:0] == laddr)
      else report_error($sformatf("R2L laddr flit %h, expected last with %h", f, laddr));
  endtask

  // Packets of up to six data words, each with header and address flit
  task automatic check_l2r(
    input int                         pos,
    input logic [`DMA_TILE_WIDTH-1:0] rtile,
    input logic [`DMA_ADDR_WIDTH-1:0] raddr,
    input logic [`DMA_ADDR_WIDTH-1:0] laddr,
    input int                         words
  );
    logic [`DMA_FLIT_WIDTH-1:0] f;
    logic [`DMA_DATA_WIDTH-1:0] exp_word;
    int                         off;
    int                         n;
    off = 0;
    while (off < words) begin
      n = (words - off < PKT_WORDS) ? words - off : PKT_WORDS;
      wait_flits(n + 2);
      f = flits.pop_front();
      check_header(f, pos, rtile, PKT_L2R_REQ, n, off + n == words);
      f = flits.pop_front();
      assert (f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] == FLIT_PAYLOAD
              && f[31:0] == 32'(raddr + 4 * off))
        else report_error($sformatf("L2R address flit %h at offset %0d", f, off));
      for (int j = 0; j < n; j++) begin
        f        = flits.pop_front();
        exp_word = 32'(laddr + 4 * (off + j)) ^ MEM_PAT;
        assert (f[31:0] == exp_word)
          else report_error($sformatf("L2R word %0d is %h, expected %h",
                                      off + j, f[31:0], exp_word));
        assert (f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB]
                == ((j == n - 1) ? FLIT_LAST : FLIT_PAYLOAD))
          else report_error($sformatf("L2R word %0d has the wrong flit type", off + j));
      end
      off = off + n;
    end
  endtask

  //////////////////////////////
  // Stimulus
  initial begin
    seed          = 10;
    clk           = 1'b0;
    rst           = 1'b1;
    cfg_req       = 1'b0;
    cfg_pos       = '0;
    cfg_dir       = DMA_L2R;
    cfg_rtile     = '0;
    cfg_raddr     = '0;
    cfg_laddr     = '0;
    cfg_size      = '0;
    done_en       = 1'b0;
    done_pos      = '0;
    noc_out_ready = 1'b0;
    mem_rdata     = '0;
    pend_addr     = '0;
    offer_valid   = 1'b0;
    offer_flit    = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    assert (!noc_out_valid && !cfg_ack && !mem_en)
      else report_error("noc_out_valid, cfg_ack or mem_en high after reset");

    // Single R2L request
    load_entry(1, DMA_R2L, 5'd7, 32'h1000_0040, 32'h0000_0200, 24);
    check_r2l(1, 5'd7, 32'h1000_0040, 32'h0000_0200, 24);
    expect_quiet();
    signal_done(1);

    // 15 words split 6, 6, 3
    load_entry(0, DMA_L2R, 5'd12, 32'h2000_0100, 32'h0000_0800, 15);
    check_l2r(0, 5'd12, 32'h2000_0100, 32'h0000_0800, 15);
    expect_quiet();
    signal_done(0);

    // Entries 0 and 2 load while 1 is on the NoC
    // Grant then moves on past 1 to 2 and wraps to 0
    load_entry(1, DMA_L2R, 5'd20, 32'h3000_0000, 32'h0000_1000, 15);
    load_entry(0, DMA_R2L, 5'd4, 32'h4000_0010, 32'h0000_1800, 100);
    load_entry(2, DMA_R2L, 5'd9, 32'h5000_0020, 32'h0000_1C00, 7);
    check_l2r(1, 5'd20, 32'h3000_0000, 32'h0000_1000, 15);
    check_r2l(2, 5'd9, 32'h5000_0020, 32'h0000_1C00, 7);
    check_r2l(0, 5'd4, 32'h4000_0010, 32'h0000_1800, 100);
    expect_quiet();

    // Only entry 2 closes and its reload is served while 0 and 1 stay open
    signal_done(2);
    load_entry(2, DMA_L2R, 5'd30, 32'h6000_0400, 32'h0000_2000, 4);
    check_l2r(2, 5'd30, 32'h6000_0400, 32'h0000_2000, 4);
    expect_quiet();
    signal_done(0);
    signal_done(1);
    signal_done(2);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== dma_noc.f ====
+incdir+design
design/dma_noc_pkg.sv
design/dma_rr_arbiter.sv
design/dma_request_table.sv
design/dma_local_reader.sv
design/dma_noc_req_gen.sv
design/dma_initiator.sv
verif/tb_dma_initiator.sv

// ==== Bender.yml ====
package:
  name: dma_noc

sources:
  - include_dirs:
      - design
    files:
      - design/dma_noc_pkg.sv
      - design/dma_rr_arbiter.sv
      - design/dma_request_table.sv
      - design/dma_local_reader.sv
      - design/dma_noc_req_gen.sv
      - design/dma_initiator.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_dma_initiator.sv
